//--- rtl/button_debounce.sv
module button_debounce #(
    parameter int DEBOUNCE_CYCLES = 250_000
) (
    input  logic clk,
    input  logic rst,
    input  logic btn,
    output logic press
);

    // Counter must reach DEBOUNCE_CYCLES - 1
    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DEBOUNCE_CYCLES - 1);

    // Two-flop synchronizer for the asynchronous button
    logic             btn_meta;
    logic             btn_sync;
    // Debounced level and its copy one cycle later
    logic             level;
    logic             level_q;
    // Cycles the synchronized input has disagreed with level
    logic [CNT_W-1:0] stable_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            btn_meta   <= 1'b0;
            btn_sync   <= 1'b0;
            level      <= 1'b0;
            level_q    <= 1'b0;
            stable_cnt <= '0;
        end else begin
            btn_meta <= btn;
            btn_sync <= btn_meta;
            level_q  <= level;
            // Any agreement restarts the count
            if (btn_sync == level) begin
                stable_cnt <= '0;
            end else if (stable_cnt == CNT_LAST) begin
                // Input held its new value long enough
                level      <= btn_sync;
                stable_cnt <= '0;
            end else begin
                stable_cnt <= stable_cnt + CNT_W'(1);
            end
        end
    end

    // One pulse per accepted rising edge
    assign press = level && !level_q;

endmodule

//--- rtl/checksum_engine.sv
module checksum_engine #(
    parameter int SECTORS_PER_GROUP = 72,
    localparam int ADDR_W = $clog2(SECTORS_PER_GROUP * sector_pkg::WORDS_PER_SECTOR)
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              group_start,
    input  logic              sum_start,
    input  sector_pkg::word_t rd_data,
    output logic [ADDR_W-1:0] rd_addr,
    output logic              sum_done,
    output sector_pkg::word_t led
);

    import sector_pkg::*;

    localparam int DEPTH = SECTORS_PER_GROUP * WORDS_PER_SECTOR;
    localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(DEPTH - 1);
    localparam logic [16:0] MOD17 = 17'(CHECKSUM_MODULUS);

    // Address issue in progress
    logic        busy;
    // rd_data holds a word this cycle, and whether it is the last one
    logic        rd_valid;
    logic        rd_last;
    word_t       acc;
    word_t       acc_next;
    logic [16:0] raw_sum;
    logic [16:0] once_sum;
    logic [16:0] twice_sum;

    // acc < modulus and the word < 2**16, so two subtractions always suffice
    always_comb begin
        raw_sum   = {1'b0, acc} + {1'b0, rd_data};
        once_sum  = (raw_sum >= MOD17) ? raw_sum - MOD17 : raw_sum;
        twice_sum = (once_sum >= MOD17) ? once_sum - MOD17 : once_sum;
        acc_next  = word_t'(twice_sum);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            rd_addr  <= '0;
            rd_valid <= 1'b0;
            rd_last  <= 1'b0;
            sum_done <= 1'b0;
            led      <= '0;
        end else begin
            // Track the one-cycle read latency
            rd_valid <= busy;
            rd_last  <= busy && (rd_addr == LAST_ADDR);
            sum_done <= rd_last;
            if (sum_start) begin
                busy    <= 1'b1;
                rd_addr <= '0;
            end else if (busy) begin
                if (rd_addr == LAST_ADDR) begin
                    busy <= 1'b0;
                end else begin
                    rd_addr <= rd_addr + ADDR_W'(1);
                end
            end
            // Result shows up together with sum_done
            if (group_start) begin
                led <= '0;
            end else if (rd_last) begin
                led <= acc_next;
            end
        end
    end

    // Running sum
    always_ff @(posedge clk) begin
        if (sum_start) begin
            acc <= '0;
        end else if (rd_valid) begin
            acc <= acc_next;
        end
    end

endmodule

//--- rtl/sector_buffer.sv
module sector_buffer #(
    parameter int SECTORS_PER_GROUP = 72,
    localparam int ADDR_W = $clog2(SECTORS_PER_GROUP * sector_pkg::WORDS_PER_SECTOR)
) (
    input  logic              clk,
    input  logic              wr_en,
    input  logic [ADDR_W-1:0] wr_addr,
    input  sector_pkg::word_t wr_data,
    input  logic [ADDR_W-1:0] rd_addr,
    output sector_pkg::word_t rd_data
);

    import sector_pkg::*;

    // One whole sector group
    localparam int DEPTH = SECTORS_PER_GROUP * WORDS_PER_SECTOR;

    word_t mem [DEPTH];

    // Write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read, data one cycle after the address
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

//--- rtl/sector_loader_top.sv
module sector_loader_top #(
    parameter int SECTORS_PER_GROUP = 72,
    parameter int DEBOUNCE_CYCLES   = 250_000
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                btn,
    input  logic                sd_ready,
    input  logic                sd_byte_available,
    input  sector_pkg::byte_t   sd_dout,
    output logic                sd_rd,
    output sector_pkg::sector_t sd_address,
    output sector_pkg::word_t   led,
    output logic                done
);

    import sector_pkg::*;

    // Buffer address width for one group
    localparam int ADDR_W = $clog2(SECTORS_PER_GROUP * WORDS_PER_SECTOR);

    // Control between the blocks
    logic              press;
    logic              group_start;
    logic              sum_start;
    logic              sum_done;
    // Buffer write side
    logic              wr_en;
    logic [ADDR_W-1:0] wr_addr;
    word_t             wr_data;
    // Buffer read side
    logic [ADDR_W-1:0] rd_addr;
    word_t             rd_data;

    button_debounce #(
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) u_button_debounce (
        .clk   (clk),
        .rst   (rst),
        .btn   (btn),
        .press (press)
    );

    sector_sequencer #(
        .SECTORS_PER_GROUP (SECTORS_PER_GROUP)
    ) u_sector_sequencer (
        .clk               (clk),
        .rst               (rst),
        .press             (press),
        .sd_ready          (sd_ready),
        .sd_byte_available (sd_byte_available),
        .sum_done          (sum_done),
        .sd_rd             (sd_rd),
        .sd_address        (sd_address),
        .group_start       (group_start),
        .sum_start         (sum_start),
        .done              (done)
    );

    // Byte strobe feeds the packer directly, no back-pressure
    word_packer #(
        .SECTORS_PER_GROUP (SECTORS_PER_GROUP)
    ) u_word_packer (
        .clk         (clk),
        .rst         (rst),
        .group_start (group_start),
        .byte_valid  (sd_byte_available),
        .byte_in     (sd_dout),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data)
    );

    sector_buffer #(
        .SECTORS_PER_GROUP (SECTORS_PER_GROUP)
    ) u_sector_buffer (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    checksum_engine #(
        .SECTORS_PER_GROUP (SECTORS_PER_GROUP)
    ) u_checksum_engine (
        .clk         (clk),
        .rst         (rst),
        .group_start (group_start),
        .sum_start   (sum_start),
        .rd_data     (rd_data),
        .rd_addr     (rd_addr),
        .sum_done    (sum_done),
        .led         (led)
    );

endmodule

//--- rtl/sector_pkg.sv
package sector_pkg;

    // Data types shared by the loader blocks

    // One byte as delivered by the SD controller
    typedef logic [7:0] byte_t;

    // One buffer word, also the width of the checksum
    typedef logic [15:0] word_t;

    // Card sector address as seen by the SD controller
    typedef logic [31:0] sector_t;

    // Card protocol constants

    // Every read returns one full sector
    localparam int BYTES_PER_SECTOR = 512;

    // Bytes are paired high byte first, so half as many words
    localparam int WORDS_PER_SECTOR = BYTES_PER_SECTOR / 2;

    // Checksum constants

    // Largest prime below 2**16
    localparam int CHECKSUM_MODULUS = 65521;

    // Sector group layout on the card

    // Distance between two group bases, in sectors
    localparam int GROUP_STRIDE = 100;

    // Groups visited before the base wraps back to sector 0
    localparam int GROUP_COUNT = 5;

endpackage

//--- rtl/sector_sequencer.sv
module sector_sequencer #(
    parameter int SECTORS_PER_GROUP = 72
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                press,
    input  logic                sd_ready,
    input  logic                sd_byte_available,
    input  logic                sum_done,
    output logic                sd_rd,
    output sector_pkg::sector_t sd_address,
    output logic                group_start,
    output logic                sum_start,
    output logic                done
);

    import sector_pkg::*;

    typedef enum logic [2:0] {
        S_START_GROUP,
        S_WAIT_READY,
        S_REQUEST,
        S_RECEIVE,
        S_WAIT_END,
        S_CHECKSUM,
        S_DONE
    } state_t;

    // Sector index within the group
    localparam int IDX_W = $clog2(SECTORS_PER_GROUP + 1);
    localparam logic [IDX_W-1:0] LAST_SECTOR = IDX_W'(SECTORS_PER_GROUP - 1);
    // Base of the last group before wrapping to 0
    localparam sector_t LAST_BASE = sector_t'(GROUP_STRIDE * (GROUP_COUNT - 1));
    localparam logic [8:0] LAST_BYTE = 9'(BYTES_PER_SECTOR - 1);

    state_t           state;
    sector_t          group_base;
    logic [IDX_W-1:0] sector_idx;
    logic [8:0]       byte_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= S_START_GROUP;
            group_base <= '0;
            sector_idx <= '0;
            byte_cnt   <= '0;
            sum_start  <= 1'b0;
        end else begin
            // sum_start is a single-cycle pulse
            sum_start <= 1'b0;
            case (state)
                S_START_GROUP: begin
                    // First sector of the group
                    sector_idx <= '0;
                    state      <= S_WAIT_READY;
                end
                S_WAIT_READY: begin
                    if (sd_ready) begin
                        state <= S_REQUEST;
                    end
                end
                S_REQUEST: begin
                    // sd_rd is high in this state only
                    byte_cnt <= '0;
                    state    <= S_RECEIVE;
                end
                S_RECEIVE: begin
                    if (sd_byte_available) begin
                        byte_cnt <= byte_cnt + 9'd1;
                        if (byte_cnt == LAST_BYTE) begin
                            state <= S_WAIT_END;
                        end
                    end
                end
                S_WAIT_END: begin
                    // Controller is idle again once ready returns
                    if (sd_ready) begin
                        if (sector_idx == LAST_SECTOR) begin
                            sum_start <= 1'b1;
                            state     <= S_CHECKSUM;
                        end else begin
                            sector_idx <= sector_idx + IDX_W'(1);
                            state      <= S_WAIT_READY;
                        end
                    end
                end
                S_CHECKSUM: begin
                    if (sum_done) begin
                        state <= S_DONE;
                    end
                end
                S_DONE: begin
                    // Only place a press has any effect
                    if (press) begin
                        if (group_base == LAST_BASE) begin
                            group_base <= '0;
                        end else begin
                            group_base <= group_base + sector_t'(GROUP_STRIDE);
                        end
                        state <= S_START_GROUP;
                    end
                end
                default: state <= S_START_GROUP;
            endcase
        end
    end

    // Outputs decoded from the state
    assign sd_rd       = (state == S_REQUEST);
    assign group_start = (state == S_START_GROUP);
    assign done        = (state == S_DONE);

    // Address only moves while the controller is idle
    assign sd_address = group_base + sector_t'(sector_idx);

endmodule

//--- rtl/word_packer.sv
module word_packer #(
    parameter int SECTORS_PER_GROUP = 72,
    localparam int ADDR_W = $clog2(SECTORS_PER_GROUP * sector_pkg::WORDS_PER_SECTOR)
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              group_start,
    input  logic              byte_valid,
    input  sector_pkg::byte_t byte_in,
    output logic              wr_en,
    output logic [ADDR_W-1:0] wr_addr,
    output sector_pkg::word_t wr_data
);

    import sector_pkg::*;

    // First byte of the current pair
    byte_t hi_byte;
    // High when hi_byte holds a byte waiting for its partner
    logic  phase;

    always_ff @(posedge clk) begin
        if (rst) begin
            phase   <= 1'b0;
            wr_en   <= 1'b0;
            wr_addr <= '0;
        end else if (group_start) begin
            // New group fills the buffer from the start
            phase   <= 1'b0;
            wr_en   <= 1'b0;
            wr_addr <= '0;
        end else begin
            wr_en <= byte_valid && phase;
            if (byte_valid) begin
                phase <= !phase;
            end
            // Advance once the pending word has gone out
            if (wr_en) begin
                wr_addr <= wr_addr + ADDR_W'(1);
            end
        end
    end

    // Pair data path
    always_ff @(posedge clk) begin
        if (byte_valid && !phase) begin
            hi_byte <= byte_in;
        end
        // High byte first
        if (byte_valid && phase) begin
            wr_data <= {hi_byte, byte_in};
        end
    end

endmodule

//--- run.sh
#!/bin/sh
# Build and run the sector loader testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -f tb.f \
    --top-module tb_sector_loader -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Simulation finished: FAIL" sim.log && exit 1
grep -q "Simulation finished: PASS" sim.log || exit 1
exit 0

//--- sim/sd_sector_model.sv
module sd_sector_model (
    input  logic                clk,
    input  logic                rst,
    input  logic                sd_rd,
    input  sector_pkg::sector_t sd_address,
    output logic                sd_ready,
    output logic                sd_byte_available,
    output sector_pkg::byte_t   sd_dout
);

    timeunit 1ns;
    timeprecision 100ps;

    import sector_pkg::*;

    // Base seed, the sector address is added on every read
    localparam int SEED = 80;

    // Sector transfer in progress
    logic        busy;
    logic [9:0]  byte_cnt;
    // Idle cycles left before the next byte
    logic [1:0]  gap;
    logic [31:0] lcg_state;
    logic [31:0] next_state;

    // Same generator the testbench uses for expected data
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    always_comb begin
        next_state = lcg_next(lcg_state);
    end

    always @(posedge clk) begin
        if (rst) begin
            sd_ready          <= 1'b1;
            sd_byte_available <= 1'b0;
            sd_dout           <= '0;
            busy              <= 1'b0;
            byte_cnt          <= '0;
            gap               <= '0;
            lcg_state         <= '0;
        end else begin
            // Byte strobe lasts one cycle
            sd_byte_available <= 1'b0;
            if (!busy) begin
                if (sd_rd) begin
                    busy      <= 1'b1;
                    sd_ready  <= 1'b0;
                    byte_cnt  <= '0;
                    gap       <= '0;
                    lcg_state <= 32'(SEED) + sd_address;
                end
            end else if (gap != 2'd0) begin
                gap <= gap - 2'd1;
            end else if (byte_cnt == 10'(BYTES_PER_SECTOR)) begin
                // Whole sector sent, controller idle again
                busy     <= 1'b0;
                sd_ready <= 1'b1;
            end else begin
                lcg_state         <= next_state;
                sd_dout           <= next_state[23:16];
                sd_byte_available <= 1'b1;
                byte_cnt          <= byte_cnt + 10'd1;
                // Uneven pace, 0 to 3 idle cycles
                gap               <= next_state[27:26];
            end
        end
    end

endmodule

//--- sim/sector_loader_props.sv
module sector_loader_props (
    input logic                clk,
    input logic                rst,
    input logic                sd_rd,
    input logic                sd_ready,
    input sector_pkg::sector_t sd_address,
    input logic                done,
    input sector_pkg::word_t   led
);

    timeunit 1ns;
    timeprecision 100ps;

    // Read request is a single-cycle pulse
    rd_single_cycle: assert property (@(posedge clk) disable iff (rst)
        sd_rd |=> !sd_rd)
        else $error("sd_rd stayed high for more than one cycle");

    // Requests only go to an idle controller
    rd_only_when_ready: assert property (@(posedge clk) disable iff (rst)
        sd_rd |-> sd_ready)
        else $error("sd_rd raised while sd_ready was low");

    // Address held for the whole transfer
    address_stable: assert property (@(posedge clk) disable iff (rst)
        !sd_ready |-> $stable(sd_address))
        else $error("sd_address changed while sd_ready was low");

    rd_not_in_done: assert property (@(posedge clk) disable iff (rst)
        !(done && sd_rd))
        else $error("done and sd_rd high in the same cycle");

    // Result frozen while shown
    led_stable_in_done: assert property (@(posedge clk) disable iff (rst)
        ($past(done) && done) |-> $stable(led))
        else $error("led changed while done was high");

endmodule

bind sector_loader_top sector_loader_props u_sector_loader_props (
    .clk        (clk),
    .rst        (rst),
    .sd_rd      (sd_rd),
    .sd_ready   (sd_ready),
    .sd_address (sd_address),
    .done       (done),
    .led        (led)
);

//--- sim/tb_sector_loader.sv
module tb_sector_loader;

    timeunit 1ns;
    timeprecision 100ps;

    import sector_pkg::*;

    localparam int SECTORS  = 2;
    localparam int DEBOUNCE = 4;
    localparam int SEED     = 80;
    localparam int TIMEOUT  = 40000;
    // Cycles for the debounced level to fall back after release
    localparam int SETTLE   = 12;

    logic    clk;
    logic    rst;
    logic    btn;
    logic    sd_rd;
    sector_t sd_address;
    logic    sd_ready;
    logic    sd_byte_available;
    byte_t   sd_dout;
    word_t   led;
    logic    done;

    // Every sector address requested, in order
    sector_t rd_addrs[$];
    int      errors;
    int      tests_run;
    int      tests_passed;
    // Set once a wait runs out, later checks are skipped
    logic    hung;
    // Reference sum of group 0 for the wrap test
    logic [31:0] group0_sum;

    sector_loader_top #(
        .SECTORS_PER_GROUP (SECTORS),
        .DEBOUNCE_CYCLES   (DEBOUNCE)
    ) u_sector_loader_top (
        .clk               (clk),
        .rst               (rst),
        .btn               (btn),
        .sd_ready          (sd_ready),
        .sd_byte_available (sd_byte_available),
        .sd_dout           (sd_dout),
        .sd_rd             (sd_rd),
        .sd_address        (sd_address),
        .led               (led),
        .done              (done)
    );

    // Card side, bytes regenerated from the sector address
    sd_sector_model u_sd_sector_model (
        .clk               (clk),
        .rst               (rst),
        .sd_rd             (sd_rd),
        .sd_address        (sd_address),
        .sd_ready          (sd_ready),
        .sd_byte_available (sd_byte_available),
        .sd_dout           (sd_dout)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Log of read requests
    always @(posedge clk) begin
        if (!rst && sd_rd) begin
            rd_addrs.push_back(sd_address);
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Sum of all words of a group, high byte first, modulo the prime
    function automatic logic [31:0] group_checksum(input int base);
        logic [31:0] st;
        logic [15:0] w;
        int          sum;
        sum = 0;
        for (int s = 0; s < SECTORS; s++) begin
            // Each sector restarts the generator at its own address
            st = 32'(SEED + base + s);
            for (int i = 0; i < WORDS_PER_SECTOR; i++) begin
                st      = lcg_next(st);
                w[15:8] = st[23:16];
                st      = lcg_next(st);
                w[7:0]  = st[23:16];
                sum     = (sum + int'(w)) % CHECKSUM_MODULUS;
            end
        end
        return 32'(sum);
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (!hung) begin
            assert (got == exp) else begin
                $display("Mismatch at %0d ns: %s, got %0d, expected %0d",
                         $time, what, got, exp);
                errors++;
            end
        end
    endtask

    task automatic wait_for_done(input logic level);
        int cycles;
        cycles = 0;
        while (!hung && done !== level && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (!hung && done !== level) begin
            $display("Timeout: done did not become %0b within %0d cycles", level, TIMEOUT);
            hung = 1'b1;
            errors++;
        end
    endtask

    task automatic wait_for_reads(input int count);
        int cycles;
        cycles = 0;
        while (!hung && rd_addrs.size() < count && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (!hung && rd_addrs.size() < count) begin
            $display("Timeout: only %0d sector reads seen, waited for %0d",
                     rd_addrs.size(), count);
            hung = 1'b1;
            errors++;
        end
    endtask

    // Button high for a number of cycles, then released until it settles
    task automatic hold_button(input int cycles);
        @(posedge clk);
        btn <= 1'b1;
        repeat (cycles) @(posedge clk);
        btn <= 1'b0;
        repeat (SETTLE) @(posedge clk);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            tests_passed++;
            $display("Test %s: ok", name);
        end else begin
            $display("Test %s: failed, %0d errors", name, errors - errors_before);
        end
    endtask

    // Press to move on, then check both addresses and the new sum
    task automatic load_group(input int base);
        int first;
        first = rd_addrs.size();
        hold_button(10);
        wait_for_done(1'b0);
        wait_for_reads(first + 2);
        check_value(rd_addrs[first], 32'(base), "first read of group");
        check_value(rd_addrs[first + 1], 32'(base + 1), "second read of group");
        wait_for_done(1'b1);
        check_value(32'(led), group_checksum(base), "group checksum");
    endtask

    initial begin
        int errs;
        int reads;
        errors       = 0;
        tests_run    = 0;
        tests_passed = 0;
        hung         = 1'b0;
        rst <= 1'b1;
        btn <= 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // Idle outputs, then the first request
        errs = errors;
        @(posedge clk);
        check_value(32'(done), 32'd0, "done after reset");
        check_value(32'(sd_rd), 32'd0, "sd_rd after reset");
        check_value(32'(led), 32'd0, "led after reset");
        wait_for_reads(1);
        check_value(rd_addrs[0], 32'd0, "first read address");
        finish_test("reset", errs);

        // Long press while the group is still loading
        errs = errors;
        hold_button(10);
        wait_for_reads(2);
        check_value(rd_addrs[1], 32'd1, "read after ignored press");
        finish_test("press_while_loading", errs);

        errs = errors;
        wait_for_done(1'b1);
        group0_sum = group_checksum(0);
        check_value(32'(led), group0_sum, "group 0 checksum");
        finish_test("group0_checksum", errs);

        // Too short to pass the debouncer
        errs  = errors;
        reads = rd_addrs.size();
        hold_button(2);
        check_value(32'(done), 32'd1, "done after short pulse");
        check_value(32'(rd_addrs.size()), 32'(reads), "reads after short pulse");
        finish_test("short_pulse", errs);

        errs = errors;
        load_group(100);
        finish_test("group_change", errs);

        // Remaining bases, then back to the first group
        errs = errors;
        load_group(200);
        load_group(300);
        load_group(400);
        load_group(0);
        check_value(32'(led), group0_sum, "checksum after wrap");
        finish_test("wrap", errs);

        $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_passed, tests_run - tests_passed, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- tb.f
rtl/sector_pkg.sv
rtl/button_debounce.sv
rtl/sector_sequencer.sv
rtl/word_packer.sv
rtl/sector_buffer.sv
rtl/checksum_engine.sv
rtl/sector_loader_top.sv
sim/sd_sector_model.sv
sim/sector_loader_props.sv
sim/tb_sector_loader.sv
